// ==== include/csi2_rx_cfg.svh ====
`ifndef CSI2_RX_CFG_SVH
`define CSI2_RX_CFG_SVH

`define CSI2_STAT_W   32
`define CSI2_PIX_W    32
`define CSI2_CRC_W    16

`define CSI2_CRC_INIT 16'hFFFF
`define CSI2_CRC_POLY 16'h8408 // Reflected x^16+x^12+x^5+1.

`endif

// ==== source/csi2_pkg.sv ====
`include "csi2_rx_cfg.svh"

package csi2_pkg;

  typedef enum logic [5:0] {
    DT_FS    = 6'h00, // Frame start.
    DT_FE    = 6'h01,
    DT_LS    = 6'h02,
    DT_LE    = 6'h03,
    DT_RAW8  = 6'h2A,
    DT_RAW10 = 6'h2B
  } csi2_dt_e;

  typedef enum logic [1:0] {
    ST_HDR,
    ST_PAYLOAD,
    ST_FOOTER,
    ST_DROP // Wait for next header.
  } pkt_state_e;

  typedef logic [`CSI2_STAT_W-1:0] stat_t;
  typedef logic [`CSI2_PIX_W-1:0]  pix_word_t;

endpackage

// ==== source/csi2_hdr_ecc.sv ====
`timescale 1ns/1ps

module csi2_hdr_ecc (
  input  logic [23:0] hdr_i,
  input  logic [5:0]  ecc_i,
  output logic [23:0] hdr_o,
  output logic        err_o,
  output logic        corr_o
);

  // Data bits covered by each parity bit, P5 down to P0.
  localparam logic [5:0][23:0] ECC_MASK = {
    24'hEFFC00,
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7
  };

  logic [5:0]       parity;
  logic [5:0]       syndrome;
  logic [23:0][5:0] ecc_col;
  logic [23:0]      flip;

  always_comb begin
    for (int k = 0; k < 6; k++) begin
      parity[k] = ^(hdr_i & ECC_MASK[k]);
      for (int i = 0; i < 24; i++)
        ecc_col[i][k] = ECC_MASK[k][i]; // Syndrome of a bad data bit.
    end
  end

  assign syndrome = parity ^ ecc_i;

  always_comb begin
    for (int i = 0; i < 24; i++)
      flip[i] = (syndrome == ecc_col[i]);
  end

  assign hdr_o = hdr_i ^ flip;
  assign err_o = |syndrome;

  // A lone syndrome bit means the ECC field itself took the hit.
  assign corr_o = (|flip) || $onehot(syndrome);

endmodule

// ==== source/csi2_crc16.sv ====
`timescale 1ns/1ps
`include "csi2_rx_cfg.svh"

module csi2_crc16 import csi2_pkg::*; (
  input  logic                   clk_i,
  input  logic                   srst_i,
  input  logic                   init_i,
  input  logic                   en_i,
  input  pix_word_t              data_i,
  input  logic                   check_i,
  input  logic [`CSI2_CRC_W-1:0] crc_rx_i,
  output logic                   bad_o
);

  logic [`CSI2_CRC_W-1:0] crc_q;

  function automatic logic [`CSI2_CRC_W-1:0] crc_word(
    input logic [`CSI2_CRC_W-1:0] crc,
    input pix_word_t              word
  );
    logic [`CSI2_CRC_W-1:0] c;
    logic                   fb;
    c = crc;
    // Byte 0 goes first and every byte goes LSB first, so bit order is plain.
    for (int i = 0; i < $bits(pix_word_t); i++) begin
      fb = c[0] ^ word[i];
      c  = c >> 1;
      if (fb)
        c = c ^ `CSI2_CRC_POLY;
    end
    return c;
  endfunction

  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i)
      crc_q <= `CSI2_CRC_INIT;
    else if (init_i)
      crc_q <= `CSI2_CRC_INIT;
    else if (en_i)
      crc_q <= crc_word(crc_q, data_i);
  end

  assign bad_o = check_i && (crc_q != crc_rx_i);

endmodule

// ==== source/csi2_pkt_ctrl.sv ====
`timescale 1ns/1ps

module csi2_pkt_ctrl import csi2_pkg::*; (
  input  logic        clk_i,
  input  logic        srst_i,
  input  logic        pkt_valid_i,
  input  logic        pkt_sop_i,
  input  pix_word_t   pkt_data_i,
  output logic [23:0] hdr_o,
  output logic [5:0]  ecc_o,
  input  logic [23:0] hdr_i,
  input  logic        hdr_err_i,
  input  logic        hdr_corr_i,
  output logic        crc_init_o,
  output logic        crc_en_o,
  output logic        crc_check_o,
  input  logic        crc_bad_i,
  output pix_word_t   video_data_o,
  output logic        video_valid_o,
  output logic        video_last_o,
  output logic        video_user_o,
  output logic        header_err_o,
  output logic        corr_header_err_o,
  output logic        crc_err_o
);

  localparam logic [5:0] DT_LONG_MIN = 6'h10;

  pkt_state_e  state;
  csi2_dt_e    hdr_dt;
  logic [13:0] words_left;
  logic        fs_flag;
  logic        hdr_vld;
  logic        body_vld;
  logic        hdr_bad;
  logic        hdr_long;
  logic        last_word;

  assign hdr_o = pkt_data_i[23:0];
  assign ecc_o = pkt_data_i[29:24];

  assign hdr_dt    = csi2_dt_e'(hdr_i[5:0]);
  assign hdr_vld   = pkt_valid_i && pkt_sop_i;
  assign body_vld  = pkt_valid_i && !pkt_sop_i;
  assign hdr_bad   = hdr_err_i && !hdr_corr_i;
  assign hdr_long  = (hdr_i[5:0] >= DT_LONG_MIN);
  assign last_word = (words_left == 14'd1);

  assign crc_init_o  = hdr_vld && !hdr_bad && hdr_long;
  assign crc_en_o    = body_vld && (state == ST_PAYLOAD);
  assign crc_check_o = body_vld && (state == ST_FOOTER);

  // A header word restarts the FSM from any state.
  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i) begin
      state      <= ST_HDR;
      words_left <= '0;
      fs_flag    <= 1'b0;
    end else if (hdr_vld) begin
      if (hdr_bad) begin
        state <= ST_DROP;
      end else if (!hdr_long) begin
        state <= ST_HDR;
        if (hdr_dt == DT_FS)
          fs_flag <= 1'b1;
      end else begin
        words_left <= hdr_i[23:10]; // Byte count to words.
        if (hdr_i[23:10] == '0)
          state <= ST_FOOTER;
        else
          state <= ST_PAYLOAD;
      end
    end else if (crc_en_o) begin
      words_left <= words_left - 1'b1;
      fs_flag    <= 1'b0;
      if (last_word)
        state <= ST_FOOTER;
    end else if (crc_check_o) begin
      state <= ST_HDR;
    end
  end

  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i) begin
      video_valid_o     <= 1'b0;
      video_last_o      <= 1'b0;
      video_user_o      <= 1'b0;
      header_err_o      <= 1'b0;
      corr_header_err_o <= 1'b0;
      crc_err_o         <= 1'b0;
    end else begin
      video_valid_o     <= crc_en_o;
      video_last_o      <= crc_en_o && last_word;
      video_user_o      <= crc_en_o && fs_flag;
      header_err_o      <= hdr_vld && hdr_err_i;
      corr_header_err_o <= hdr_vld && hdr_corr_i;
      crc_err_o         <= crc_check_o && crc_bad_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (crc_en_o)
      video_data_o <= pkt_data_i;
  end

endmodule

// ==== source/csi2_stat_acc.sv ====
`timescale 1ns/1ps

module csi2_stat_acc import csi2_pkg::*; (
  input  logic  clk_i,
  input  logic  srst_i,
  input  logic  clear_stat_i,
  input  logic  video_valid_i,
  input  logic  video_last_i,
  input  logic  video_user_i,
  input  logic  header_err_i,
  input  logic  corr_header_err_i,
  input  logic  crc_err_i,
  output stat_t header_err_cnt_o,
  output stat_t corr_header_err_cnt_o,
  output stat_t crc_err_cnt_o,
  output stat_t max_ln_per_frame_o,
  output stat_t min_ln_per_frame_o,
  output stat_t max_px_per_ln_o,
  output stat_t min_px_per_ln_o
);

  stat_t px_cnt;
  stat_t px_len;
  stat_t ln_cnt;
  logic  frame_seen;
  logic  line_end;
  logic  frame_start;

  assign line_end    = video_valid_i && video_last_i;
  assign frame_start = video_valid_i && video_user_i;
  assign px_len      = px_cnt + 1'b1;

  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i) begin
      header_err_cnt_o      <= '0;
      corr_header_err_cnt_o <= '0;
      crc_err_cnt_o         <= '0;
    end else if (clear_stat_i) begin
      header_err_cnt_o      <= '0;
      corr_header_err_cnt_o <= '0;
      crc_err_cnt_o         <= '0;
    end else begin
      if (header_err_i)
        header_err_cnt_o <= header_err_cnt_o + 1'b1;
      if (header_err_i && corr_header_err_i) // Fixed headers only.
        corr_header_err_cnt_o <= corr_header_err_cnt_o + 1'b1;
      if (crc_err_i)
        crc_err_cnt_o <= crc_err_cnt_o + 1'b1;
    end
  end

  // Running counts are not touched by a clear.
  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i) begin
      px_cnt     <= '0;
      ln_cnt     <= '0;
      frame_seen <= 1'b0;
    end else if (video_valid_i) begin
      px_cnt <= video_last_i ? '0 : px_len;
      if (video_user_i) begin
        ln_cnt     <= video_last_i ? stat_t'(1) : '0; // One-word first line.
        frame_seen <= 1'b1;
      end else if (video_last_i) begin
        ln_cnt <= ln_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i) begin
      max_px_per_ln_o <= '0;
      min_px_per_ln_o <= '1;
    end else if (clear_stat_i) begin
      max_px_per_ln_o <= '0;
      min_px_per_ln_o <= '1;
    end else if (line_end) begin
      if (px_len > max_px_per_ln_o)
        max_px_per_ln_o <= px_len;
      if (px_len < min_px_per_ln_o)
        min_px_per_ln_o <= px_len;
    end
  end

  // Frame length is known only when the next frame starts.
  always_ff @(posedge clk_i, posedge srst_i) begin
    if (srst_i) begin
      max_ln_per_frame_o <= '0;
      min_ln_per_frame_o <= '1;
    end else if (clear_stat_i) begin
      max_ln_per_frame_o <= '0;
      min_ln_per_frame_o <= '1;
    end else if (frame_start && frame_seen) begin
      if (ln_cnt > max_ln_per_frame_o)
        max_ln_per_frame_o <= ln_cnt;
      if (ln_cnt < min_ln_per_frame_o)
        min_ln_per_frame_o <= ln_cnt;
    end
  end

endmodule

// ==== source/csi2_rx_stat.sv ====
`timescale 1ns/1ps
`include "csi2_rx_cfg.svh"

module csi2_rx_stat import csi2_pkg::*; (
  input  logic      clk_i,
  input  logic      srst_i,
  input  logic      clear_stat_i,
  input  logic      pkt_valid_i,
  input  logic      pkt_sop_i,
  input  pix_word_t pkt_data_i,
  output pix_word_t video_data_o,
  output logic      video_valid_o,
  output logic      video_last_o,
  output logic      video_user_o,
  output stat_t     header_err_cnt_o,
  output stat_t     corr_header_err_cnt_o,
  output stat_t     crc_err_cnt_o,
  output stat_t     max_ln_per_frame_o,
  output stat_t     min_ln_per_frame_o,
  output stat_t     max_px_per_ln_o,
  output stat_t     min_px_per_ln_o
);

  logic [23:0] hdr_raw;
  logic [5:0]  ecc_raw;
  logic [23:0] hdr_fix;
  logic        hdr_err;
  logic        hdr_corr;
  logic        crc_init;
  logic        crc_en;
  logic        crc_check;
  logic        crc_bad;
  logic        header_err;
  logic        corr_header_err;
  logic        crc_err;

  csi2_pkt_ctrl u_ctrl (
    .clk_i             (clk_i),
    .srst_i            (srst_i),
    .pkt_valid_i       (pkt_valid_i),
    .pkt_sop_i         (pkt_sop_i),
    .pkt_data_i        (pkt_data_i),
    .hdr_o             (hdr_raw),
    .ecc_o             (ecc_raw),
    .hdr_i             (hdr_fix),
    .hdr_err_i         (hdr_err),
    .hdr_corr_i        (hdr_corr),
    .crc_init_o        (crc_init),
    .crc_en_o          (crc_en),
    .crc_check_o       (crc_check),
    .crc_bad_i         (crc_bad),
    .video_data_o      (video_data_o),
    .video_valid_o     (video_valid_o),
    .video_last_o      (video_last_o),
    .video_user_o      (video_user_o),
    .header_err_o      (header_err),
    .corr_header_err_o (corr_header_err),
    .crc_err_o         (crc_err)
  );

  csi2_hdr_ecc u_ecc (
    .hdr_i  (hdr_raw),
    .ecc_i  (ecc_raw),
    .hdr_o  (hdr_fix),
    .err_o  (hdr_err),
    .corr_o (hdr_corr)
  );

  csi2_crc16 u_crc (
    .clk_i    (clk_i),
    .srst_i   (srst_i),
    .init_i   (crc_init),
    .en_i     (crc_en),
    .data_i   (pkt_data_i),
    .check_i  (crc_check),
    .crc_rx_i (pkt_data_i[`CSI2_CRC_W-1:0]), // Footer CRC field.
    .bad_o    (crc_bad)
  );

  csi2_stat_acc u_stat (
    .clk_i                 (clk_i),
    .srst_i                (srst_i),
    .clear_stat_i          (clear_stat_i),
    .video_valid_i         (video_valid_o),
    .video_last_i          (video_last_o),
    .video_user_i          (video_user_o),
    .header_err_i          (header_err),
    .corr_header_err_i     (corr_header_err),
    .crc_err_i             (crc_err),
    .header_err_cnt_o      (header_err_cnt_o),
    .corr_header_err_cnt_o (corr_header_err_cnt_o),
    .crc_err_cnt_o         (crc_err_cnt_o),
    .max_ln_per_frame_o    (max_ln_per_frame_o),
    .min_ln_per_frame_o    (min_ln_per_frame_o),
    .max_px_per_ln_o       (max_px_per_ln_o),
    .min_px_per_ln_o       (min_px_per_ln_o)
  );

endmodule

// ==== tests/csi2_rx_stat_chk.sv ====
`timescale 1ns/1ps

module csi2_rx_stat_chk import csi2_pkg::*; (
  input logic       clk_i,
  input logic       srst_i,
  input pkt_state_e state_i,
  input logic       video_valid_i,
  input logic       video_last_i,
  input logic       crc_err_i
);

  a_last_in_valid: assert property (@(posedge clk_i) disable iff (srst_i)
    video_last_i |-> video_valid_i)
    else $error("video_last_o high without video_valid_o.");

  a_crc_apart: assert property (@(posedge clk_i) disable iff (srst_i)
    !(crc_err_i && video_valid_i))
    else $error("crc_err_o and video_valid_o high together.");

  // A dropped packet must not leak payload.
  a_drop_quiet: assert property (@(posedge clk_i) disable iff (srst_i)
    (state_i == ST_DROP) |=> !video_valid_i)
    else $error("Video word produced from ST_DROP.");

endmodule

bind csi2_pkt_ctrl csi2_rx_stat_chk u_chk (
  .clk_i         (clk_i),
  .srst_i        (srst_i),
  .state_i       (state),
  .video_valid_i (video_valid_o),
  .video_last_i  (video_last_o),
  .crc_err_i     (crc_err_o)
);

// ==== tests/csi2_rx_stat_tb.sv ====
`timescale 1ns/1ps
`include "csi2_rx_cfg.svh"

module csi2_rx_stat_tb import csi2_pkg::*; ();

  typedef struct packed {logic valid; logic sop; pix_word_t data;} stim_t;
  typedef struct packed {pix_word_t data; logic last; logic user;} vid_t;

  // Parity column of each header bit D0 to D23, from the CSI-2 ECC table.
  localparam logic [5:0] ECC_COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
  };

  logic      clk_i = 1'b0;
  logic      srst_i;
  logic      clear_stat_i;
  logic      pkt_valid_i;
  logic      pkt_sop_i;
  pix_word_t pkt_data_i;
  pix_word_t video_data_o;
  logic      video_valid_o;
  logic      video_last_o;
  logic      video_user_o;
  stat_t     header_err_cnt_o, corr_header_err_cnt_o, crc_err_cnt_o;
  stat_t     max_ln_per_frame_o, min_ln_per_frame_o, max_px_per_ln_o, min_px_per_ln_o;

  stim_t stim_q[$];
  vid_t  exp_q[$];
  vid_t  exp_vid;
  stat_t m_hdr_err, m_corr_err, m_crc_err;
  stat_t m_max_px, m_min_px, m_max_ln, m_min_ln;
  stat_t ln_cnt, px_cnt;
  logic  frame_seen;
  logic  fs_pend; // FS seen, first payload word not yet.
  int    cycle_cnt = 0;
  int    cycle_limit = 32'h7fff_ffff;

  csi2_rx_stat u_dut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [5:0] calc_ecc(input logic [23:0] hdr);
    logic [5:0] e;
    e = '0;
    for (int i = 0; i < 24; i++)
      if (hdr[i])
        e = e ^ ECC_COL[i];
    return e;
  endfunction

  function automatic logic [15:0] calc_crc(input logic [15:0] crc, input pix_word_t word);
    logic [15:0] c;
    logic [7:0]  b;
    c = crc;
    for (int n = 0; n < 4; n++) begin
      b = word[8*n +: 8];
      for (int k = 0; k < 8; k++) begin
        if (c[0] ^ b[k])
          c = (c >> 1) ^ `CSI2_CRC_POLY;
        else
          c = c >> 1;
      end
    end
    return c;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_word(input string name, input pix_word_t got, input pix_word_t exp);
    if (got !== exp)
      stop_run($sformatf("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic compare_stat(input string name, input stat_t got, input stat_t exp);
    if (got !== exp)
      stop_run($sformatf("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic push_gap(input int max_len);
    repeat ($urandom_range(0, max_len))
      stim_q.push_back({1'b0, 1'b0, pix_word_t'($urandom)});
  endtask

  task automatic push_header(input csi2_dt_e dt, input logic [15:0] wc, output logic dropped);
    logic [23:0] hdr;
    pix_word_t   word;
    int          r;
    int          b0;
    int          b1;
    hdr  = {wc, 2'($urandom), dt};
    word = {2'b00, calc_ecc(hdr), hdr};
    r    = $urandom_range(0, 9);
    b0   = $urandom_range(0, 29);
    b1   = (b0 + $urandom_range(1, 29)) % 30; // Distinct from b0.
    if (r >= 7)
      word[b0] = ~word[b0];
    if (r == 9)
      word[b1] = ~word[b1];
    if (r >= 7)
      m_hdr_err = m_hdr_err + 1'b1;
    if (r inside {7, 8})
      m_corr_err = m_corr_err + 1'b1;
    dropped = (r == 9); // Double errors cannot be fixed.
    stim_q.push_back({1'b1, 1'b1, word});
  endtask

  task automatic push_short(input csi2_dt_e dt);
    logic dropped;
    push_gap(3);
    push_header(dt, 16'($urandom), dropped);
    if (!dropped && dt == DT_FS)
      fs_pend = 1'b1;
  endtask

  task automatic model_video(input pix_word_t data, input logic last);
    exp_q.push_back({data, last, fs_pend});
    if (fs_pend) begin
      if (frame_seen) begin
        if (ln_cnt > m_max_ln)
          m_max_ln = ln_cnt;
        if (ln_cnt < m_min_ln)
          m_min_ln = ln_cnt;
      end
      ln_cnt     = '0;
      frame_seen = 1'b1;
    end
    fs_pend = 1'b0;
    px_cnt  = px_cnt + 1'b1;
    if (last) begin
      if (px_cnt > m_max_px)
        m_max_px = px_cnt;
      if (px_cnt < m_min_px)
        m_min_px = px_cnt;
      px_cnt = '0;
      ln_cnt = ln_cnt + 1'b1;
    end
  endtask

  task automatic push_line();
    logic        dropped;
    logic        bad;
    logic [15:0] crc;
    pix_word_t   data;
    int          n;
    push_short(DT_LS);
    push_gap(3);
    n = $urandom_range(1, 8);
    push_header(DT_RAW8, 16'(n * 4), dropped);
    crc = `CSI2_CRC_INIT;
    for (int i = 0; i < n; i++) begin
      push_gap(1);
      data = $urandom;
      crc  = calc_crc(crc, data);
      stim_q.push_back({1'b1, 1'b0, data});
      if (!dropped)
        model_video(data, i == n - 1);
    end
    bad = ($urandom_range(0, 5) == 0);
    if (bad)
      crc = crc ^ 16'($urandom_range(1, 16'hFFFF));
    if (bad && !dropped)
      m_crc_err = m_crc_err + 1'b1; // Footer of a dropped packet is ignored.
    push_gap(1);
    stim_q.push_back({1'b1, 1'b0, 16'h0000, crc});
    push_short(DT_LE);
  endtask

  always @(negedge clk_i) begin
    if (!srst_i && video_valid_o) begin
      if (exp_q.size() == 0) begin
        stop_run("Video word seen while the model expected none.");
      end else begin
        exp_vid = exp_q.pop_front();
        check_word("video_data_o", video_data_o, exp_vid.data);
        expect_flag("video_last_o", video_last_o, exp_vid.last);
        expect_flag("video_user_o", video_user_o, exp_vid.user);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
      stop_run("Timeout: the run went past its cycle limit.");
  end

  initial begin
    void'($urandom(32'hc2f2c2c4));
    srst_i       = 1'b1;
    clear_stat_i = 1'b0;
    pkt_valid_i  = 1'b0;
    pkt_sop_i    = 1'b0;
    pkt_data_i   = '0;
    {m_hdr_err, m_corr_err, m_crc_err, m_max_px, m_max_ln} = '0;
    m_min_px   = '1;
    m_min_ln   = '1;
    ln_cnt     = '0;
    px_cnt     = '0;
    frame_seen = 1'b0;
    fs_pend    = 1'b0;
    repeat (12) begin
      push_short(DT_FS);
      repeat ($urandom_range(2, 6))
        push_line();
      push_short(DT_FE);
    end
    cycle_limit = 16 + stim_q.size() + 64; // Reset, stimulus, flush and clear.
    repeat (16) @(posedge clk_i);
    srst_i <= 1'b0;
    foreach (stim_q[i]) begin
      @(posedge clk_i);
      pkt_valid_i <= stim_q[i].valid;
      pkt_sop_i   <= stim_q[i].sop;
      pkt_data_i  <= stim_q[i].data;
    end
    @(posedge clk_i);
    pkt_valid_i <= 1'b0;
    pkt_sop_i   <= 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    compare_stat("header_err_cnt_o", header_err_cnt_o, m_hdr_err);
    compare_stat("corr_header_err_cnt_o", corr_header_err_cnt_o, m_corr_err);
    compare_stat("crc_err_cnt_o", crc_err_cnt_o, m_crc_err);
    compare_stat("max_px_per_ln_o", max_px_per_ln_o, m_max_px);
    compare_stat("min_px_per_ln_o", min_px_per_ln_o, m_min_px);
    compare_stat("max_ln_per_frame_o", max_ln_per_frame_o, m_max_ln);
    compare_stat("min_ln_per_frame_o", min_ln_per_frame_o, m_min_ln);
    @(posedge clk_i);
    clear_stat_i <= 1'b1;
    @(posedge clk_i);
    clear_stat_i <= 1'b0;
    @(negedge clk_i);
    compare_stat("header_err_cnt_o", header_err_cnt_o, '0);
    compare_stat("corr_header_err_cnt_o", corr_header_err_cnt_o, '0);
    compare_stat("crc_err_cnt_o", crc_err_cnt_o, '0);
    compare_stat("max_px_per_ln_o", max_px_per_ln_o, '0);
    compare_stat("min_px_per_ln_o", min_px_per_ln_o, '1);
    compare_stat("max_ln_per_frame_o", max_ln_per_frame_o, '0);
    compare_stat("min_ln_per_frame_o", min_ln_per_frame_o, '1);
    if (exp_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_run("Expected video words never came out of the DUT.");
    end
  end

endmodule

// ==== csi2_rx_stat.f ====
+incdir+include
source/csi2_pkg.sv
source/csi2_hdr_ecc.sv
source/csi2_crc16.sv
source/csi2_pkt_ctrl.sv
source/csi2_stat_acc.sv
source/csi2_rx_stat.sv
tests/csi2_rx_stat_chk.sv
tests/csi2_rx_stat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module csi2_rx_stat_tb \
    -Mdir obj_dir -o csi2_rx_stat_sim -f csi2_rx_stat.f \
  && ./obj_dir/csi2_rx_stat_sim; } > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
